// File: Makefile
TOP := tb_axil_subsystem
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	rm -f $(LOG)
	verilator --binary --timing --assert -f files.f --top-module $(TOP) \
		-Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: design/axil_defs.svh
`ifndef AXIL_DEFS_SVH
`define AXIL_DEFS_SVH

// Bus widths
`define AXIL_AW 32
`define AXIL_DW 32

// Register bank size in 32-bit words
`define AXIL_NREGS 16

// Identification word returned by register 0
`define AXIL_ID_VALUE 32'hA11C_0001

`endif

// File: design/axil_master.sv
`timescale 1ns/1ns

module axil_master (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                cmd_valid,
    output logic                cmd_ready,
    input  cmd_pkg::cmd_req_t   cmd_req,
    output logic                rsp_valid,
    input  logic                rsp_ready,
    output cmd_pkg::cmd_rsp_t   rsp,
    output logic                aw_valid,
    input  logic                aw_ready,
    output axil_pkg::aw_chan_t  aw,
    output logic                w_valid,
    input  logic                w_ready,
    output axil_pkg::w_chan_t   w,
    input  logic                b_valid,
    output logic                b_ready,
    input  axil_pkg::b_chan_t   b,
    output logic                ar_valid,
    input  logic                ar_ready,
    output axil_pkg::ar_chan_t  ar,
    input  logic                r_valid,
    output logic                r_ready,
    input  axil_pkg::r_chan_t   r
);
    import cmd_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_WADDR,
        S_WRESP,
        S_RADDR,
        S_RDATA,
        S_RESP
    } state_e;

    state_e   state_q;
    state_e   state_d;
    cmd_req_t cmd_q;
    cmd_rsp_t rsp_q;
    logic     aw_done_q;
    logic     w_done_q;
    logic     cmd_hs;
    logic     aw_hs;
    logic     w_hs;
    logic     b_hs;
    logic     ar_hs;
    logic     r_hs;

    assign cmd_hs = cmd_valid && cmd_ready;
    assign aw_hs  = aw_valid && aw_ready;
    assign w_hs   = w_valid && w_ready;
    assign b_hs   = b_valid && b_ready;
    assign ar_hs  = ar_valid && ar_ready;
    assign r_hs   = r_valid && r_ready;

    assign cmd_ready = (state_q == S_IDLE);
    assign rsp_valid = (state_q == S_RESP);
    assign rsp       = rsp_q;

    // AW and W may finish apart and each drops once done
    assign aw_valid = (state_q == S_WADDR) && !aw_done_q;
    assign w_valid  = (state_q == S_WADDR) && !w_done_q;
    assign b_ready  = (state_q == S_WADDR) || (state_q == S_WRESP);
    assign ar_valid = (state_q == S_RADDR);
    assign r_ready  = (state_q == S_RADDR) || (state_q == S_RDATA);

    assign aw = '{addr: cmd_q.addr};
    assign w  = '{data: cmd_q.data, strb: cmd_q.strb};
    assign ar = '{addr: cmd_q.addr};

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (cmd_hs) begin
                    state_d = (cmd_req.kind == CMD_WRITE) ? S_WADDR : S_RADDR;
                end
            end
            S_WADDR: begin
                if ((aw_done_q || aw_hs) && (w_done_q || w_hs)) begin
                    state_d = S_WRESP;
                end
            end
            S_WRESP: begin
                if (b_hs) begin
                    state_d = S_RESP;
                end
            end
            S_RADDR: begin
                if (ar_hs) begin
                    state_d = S_RDATA;
                end
            end
            S_RDATA: begin
                if (r_hs) begin
                    state_d = S_RESP;
                end
            end
            S_RESP: begin
                if (rsp_ready) begin
                    state_d = S_IDLE;
                end
            end
            default: state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_q   <= S_IDLE;
            aw_done_q <= 1'b0;
            w_done_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            if (cmd_hs) begin
                aw_done_q <= 1'b0;
                w_done_q  <= 1'b0;
            end else begin
                aw_done_q <= aw_done_q || aw_hs;
                w_done_q  <= w_done_q || w_hs;
            end
        end
    end

    // Command and response payload
    always_ff @(posedge clk_i) begin
        if (cmd_hs) begin
            cmd_q <= cmd_req;
        end
        if (b_hs) begin
            rsp_q <= '{data: '0, resp: b.resp};
        end else if (r_hs) begin
            rsp_q <= '{data: r.data, resp: r.resp};
        end
    end

    a_aw_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        aw_valid && !aw_ready |=> aw_valid && $stable(aw));
    a_w_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        w_valid && !w_ready |=> w_valid && $stable(w));
    a_ar_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar));
    a_rsp_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp));
    a_rsp_after_bus: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $rose(rsp_valid) |-> $past(b_hs || r_hs));

endmodule

// File: design/axil_pkg.sv
`include "axil_defs.svh"

package axil_pkg;

    // Bus vectors
    typedef logic [`AXIL_AW-1:0] addr_t;
    typedef logic [`AXIL_DW-1:0] data_t;
    typedef logic [`AXIL_DW/8-1:0] strb_t;

    // Response codes, only OKAY and SLVERR are produced here
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } resp_e;

    // Write address
    typedef struct packed {
        addr_t addr;
    } aw_chan_t;

    // Write data
    typedef struct packed {
        data_t data;
        strb_t strb;
    } w_chan_t;

    // Write response
    typedef struct packed {
        resp_e resp;
    } b_chan_t;

    // Read address
    typedef struct packed {
        addr_t addr;
    } ar_chan_t;

    // Read data
    typedef struct packed {
        data_t data;
        resp_e resp;
    } r_chan_t;

endpackage

// File: design/axil_reg_slave.sv
`timescale 1ns/1ns
`include "axil_defs.svh"

module axil_reg_slave (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                aw_valid,
    output logic                aw_ready,
    input  axil_pkg::aw_chan_t  aw,
    input  logic                w_valid,
    output logic                w_ready,
    input  axil_pkg::w_chan_t   w,
    output logic                b_valid,
    input  logic                b_ready,
    output axil_pkg::b_chan_t   b,
    input  logic                ar_valid,
    output logic                ar_ready,
    input  axil_pkg::ar_chan_t  ar,
    output logic                r_valid,
    input  logic                r_ready,
    output axil_pkg::r_chan_t   r
);
    import axil_pkg::*;

    localparam int IDX_W  = $clog2(`AXIL_NREGS);
    localparam int NBYTES = `AXIL_DW / 8;

    typedef logic [IDX_W-1:0] idx_t;

    data_t regs [`AXIL_NREGS];
    idx_t  wr_idx;
    idx_t  rd_idx;
    logic  wr_in_range;
    logic  rd_in_range;
    logic  wr_ok;
    logic  wr_fire;
    logic  rd_fire;
    data_t rd_word;
    resp_e rd_resp;

    // Word index sits above the byte offset, anything higher is out of the bank
    assign wr_idx      = aw.addr[2 +: IDX_W];
    assign rd_idx      = ar.addr[2 +: IDX_W];
    assign wr_in_range = (aw.addr[`AXIL_AW-1:IDX_W+2] == '0);
    assign rd_in_range = (ar.addr[`AXIL_AW-1:IDX_W+2] == '0);
    assign wr_ok       = wr_in_range && (wr_idx != '0);

    // AW and W taken together, held off while B is outstanding
    assign wr_fire  = aw_valid && w_valid && !b_valid;
    assign aw_ready = wr_fire;
    assign w_ready  = wr_fire;

    assign ar_ready = !r_valid;
    assign rd_fire  = ar_valid && ar_ready;

    always_comb begin
        if (!rd_in_range) begin
            rd_word = '0;
            rd_resp = SLVERR;
        end else if (rd_idx == '0) begin
            rd_word = `AXIL_ID_VALUE;
            rd_resp = OKAY;
        end else begin
            rd_word = regs[rd_idx];
            rd_resp = OKAY;
        end
    end

    // Register bank with byte strobes
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            regs <= '{default: '0};
        end else if (wr_fire && wr_ok) begin
            for (int i = 0; i < NBYTES; i++) begin
                if (w.strb[i]) begin
                    regs[wr_idx][8*i +: 8] <= w.data[8*i +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            b_valid <= 1'b0;
            r_valid <= 1'b0;
        end else begin
            if (wr_fire) begin
                b_valid <= 1'b1;
            end else if (b_ready) begin
                b_valid <= 1'b0;
            end
            if (rd_fire) begin
                r_valid <= 1'b1;
            end else if (r_ready) begin
                r_valid <= 1'b0;
            end
        end
    end

    // Response payloads
    always_ff @(posedge clk_i) begin
        if (wr_fire) begin
            b <= '{resp: wr_ok ? OKAY : SLVERR};
        end
        if (rd_fire) begin
            r <= '{data: rd_word, resp: rd_resp};
        end
    end

    a_b_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        b_valid && !b_ready |=> b_valid && $stable(b));
    a_r_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        r_valid && !r_ready |=> r_valid && $stable(r));

endmodule

// File: design/axil_subsystem.sv
`timescale 1ns/1ns

module axil_subsystem (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              cmd_valid,
    output logic              cmd_ready,
    input  cmd_pkg::cmd_req_t cmd_req,
    output logic              rsp_valid,
    input  logic              rsp_ready,
    output cmd_pkg::cmd_rsp_t rsp
);
    import axil_pkg::*;

    // Internal AXI4-Lite bus
    logic     aw_valid;
    logic     aw_ready;
    aw_chan_t aw;
    logic     w_valid;
    logic     w_ready;
    w_chan_t  w;
    logic     b_valid;
    logic     b_ready;
    b_chan_t  b;
    logic     ar_valid;
    logic     ar_ready;
    ar_chan_t ar;
    logic     r_valid;
    logic     r_ready;
    r_chan_t  r;

    axil_master u_master (
        .*
    );

    axil_reg_slave u_slave (
        .*
    );

endmodule

// File: design/cmd_pkg.sv
package cmd_pkg;

    typedef enum logic {
        CMD_READ  = 1'b0,
        CMD_WRITE = 1'b1
    } cmd_kind_e;

    // One single-beat command
    typedef struct packed {
        cmd_kind_e      kind;
        axil_pkg::addr_t addr;
        axil_pkg::data_t data;
        axil_pkg::strb_t strb;
    } cmd_req_t;

    // Read data is zero on writes
    typedef struct packed {
        axil_pkg::data_t data;
        axil_pkg::resp_e resp;
    } cmd_rsp_t;

endpackage

// File: files.f
+incdir+design
design/axil_pkg.sv
design/cmd_pkg.sv
design/axil_master.sv
design/axil_reg_slave.sv
design/axil_subsystem.sv
verif/tb_axil_subsystem.sv

// File: verif/tb_axil_subsystem.sv
`timescale 1ns/1ns
`include "axil_defs.svh"

module tb_axil_subsystem;
    import axil_pkg::*;
    import cmd_pkg::*;

    localparam int CLK_PERIOD = 4;
    // Total commands in all tests with at most 20 cycles per command
    localparam int NUM_CMDS   = 109;
    localparam int TIMEOUT_NS = (NUM_CMDS * 20 + 100) * CLK_PERIOD;

    logic     clk_i;
    logic     rst_ni;
    logic     cmd_valid;
    logic     cmd_ready;
    cmd_req_t cmd_req;
    logic     rsp_valid;
    logic     rsp_ready;
    cmd_rsp_t rsp;

    data_t ref_bank [`AXIL_NREGS];
    int    errors;
    int    checks;

    axil_subsystem DUT (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd_req   (cmd_req),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp       (rsp)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    task automatic check_data(input string test, input data_t exp, input data_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("ERROR [%s] data expected %h actual %h", test, exp, act);
        end
    endtask

    task automatic check_resp(input string test, input resp_e exp, input resp_e act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("ERROR [%s] resp expected %s actual %s", test, exp.name(), act.name());
        end
    endtask

    task automatic flag_failure(input string test, input string what);
        errors++;
        $display("[%s] %s", test, what);
    endtask

    function automatic data_t merge_bytes(input data_t old_word, input data_t new_word,
                                          input strb_t strb);
        data_t merged;
        merged = old_word;
        for (int i = 0; i < `AXIL_DW / 8; i++) begin
            if (strb[i]) begin
                merged[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return merged;
    endfunction

    function automatic addr_t reg_addr(input int idx);
        return addr_t'(idx * 4);
    endfunction

    // Runs one command and keeps rsp_ready low for hold cycles after rsp_valid
    task automatic run_cmd(input cmd_kind_e cmd_kind, input addr_t cmd_addr,
                           input data_t cmd_data, input strb_t cmd_strb, input int hold,
                           input string test, output cmd_rsp_t rsp_o);
        int wait_cycles;
        @(negedge clk_i);
        rsp_ready      = (hold == 0);
        cmd_req.kind   = cmd_kind;
        cmd_req.addr   = cmd_addr;
        cmd_req.data   = cmd_data;
        cmd_req.strb   = cmd_strb;
        cmd_valid      = 1'b1;
        while (!cmd_ready) begin
            @(negedge clk_i);
        end
        @(negedge clk_i);
        cmd_valid    = 1'b0;
        // Master must work from its captured copy
        cmd_req.addr = $urandom();
        cmd_req.data = $urandom();
        cmd_req.strb = strb_t'($urandom());
        wait_cycles  = 0;
        while (!rsp_valid) begin
            @(negedge clk_i);
            wait_cycles++;
        end
        rsp_o = rsp;
        if (hold > 0) begin
            repeat (hold) begin
                @(negedge clk_i);
                if (!rsp_valid) begin
                    flag_failure(test, "rsp_valid dropped while rsp_ready was low");
                end
                if (cmd_ready) begin
                    flag_failure(test, "cmd_ready rose before the response was taken");
                end
                check_data(test, rsp_o.data, rsp.data);
                check_resp(test, rsp_o.resp, rsp.resp);
            end
            rsp_ready = 1'b1;
        end else if (wait_cycles + 1 != 3) begin
            flag_failure(test, $sformatf("acceptance to response took %0d cycles, not 3",
                                         wait_cycles + 1));
        end
        @(negedge clk_i);
        if (rsp_valid || !cmd_ready) begin
            flag_failure(test, "DUT did not return to idle after the response was taken");
        end
    endtask

    task automatic do_write(input addr_t addr, input data_t data, input strb_t strb,
                            input int hold, input string test, output cmd_rsp_t rsp_o);
        run_cmd(CMD_WRITE, addr, data, strb, hold, test, rsp_o);
        check_data({test, " write data"}, '0, rsp_o.data);
    endtask

    task automatic do_read(input addr_t addr, input int hold, input string test,
                           output cmd_rsp_t rsp_o);
        run_cmd(CMD_READ, addr, '0, '0, hold, test, rsp_o);
    endtask

    task automatic test_reset_values();
        cmd_rsp_t r_rsp;
        do_read(reg_addr(0), 0, "reset_id", r_rsp);
        check_data("reset_id", `AXIL_ID_VALUE, r_rsp.data);
        check_resp("reset_id", OKAY, r_rsp.resp);
        for (int i = 1; i < `AXIL_NREGS; i++) begin
            do_read(reg_addr(i), 0, "reset_values", r_rsp);
            check_data("reset_values", ref_bank[i], r_rsp.data);
            check_resp("reset_values", OKAY, r_rsp.resp);
        end
    endtask

    task automatic test_full_writes();
        cmd_rsp_t r_rsp;
        data_t    word;
        for (int i = 1; i < `AXIL_NREGS; i++) begin
            word = $urandom();
            do_write(reg_addr(i), word, 4'hF, 0, "full_write", r_rsp);
            check_resp("full_write", OKAY, r_rsp.resp);
            ref_bank[i] = word;
            do_read(reg_addr(i), 0, "full_readback", r_rsp);
            check_data("full_readback", ref_bank[i], r_rsp.data);
            check_resp("full_readback", OKAY, r_rsp.resp);
        end
    endtask

    task automatic test_partial_strobes();
        cmd_rsp_t r_rsp;
        data_t    word;
        strb_t    strb;
        for (int i = 1; i < `AXIL_NREGS; i++) begin
            word = $urandom();
            strb = strb_t'($urandom_range(14, 1));
            do_write(reg_addr(i), word, strb, 0, "partial_write", r_rsp);
            check_resp("partial_write", OKAY, r_rsp.resp);
            ref_bank[i] = merge_bytes(ref_bank[i], word, strb);
            do_read(reg_addr(i), 0, "partial_readback", r_rsp);
            check_data("partial_readback", ref_bank[i], r_rsp.data);
        end
    endtask

    task automatic test_error_responses();
        cmd_rsp_t r_rsp;
        addr_t    bad_addr [3];
        bad_addr[0] = 32'h0000_0040;
        bad_addr[1] = 32'h0000_1004;
        bad_addr[2] = 32'h8000_0008;
        do_write(reg_addr(0), $urandom(), 4'hF, 0, "write_id_reg", r_rsp);
        check_resp("write_id_reg", SLVERR, r_rsp.resp);
        foreach (bad_addr[k]) begin
            do_write(bad_addr[k], $urandom(), 4'hF, 0, "write_out_of_range", r_rsp);
            check_resp("write_out_of_range", SLVERR, r_rsp.resp);
            do_read(bad_addr[k], 0, "read_out_of_range", r_rsp);
            check_data("read_out_of_range", '0, r_rsp.data);
            check_resp("read_out_of_range", SLVERR, r_rsp.resp);
        end
        do_read(reg_addr(0), 0, "bank_unchanged", r_rsp);
        check_data("bank_unchanged", `AXIL_ID_VALUE, r_rsp.data);
        for (int i = 1; i < `AXIL_NREGS; i++) begin
            do_read(reg_addr(i), 0, "bank_unchanged", r_rsp);
            check_data("bank_unchanged", ref_bank[i], r_rsp.data);
        end
    endtask

    task automatic test_response_stall();
        cmd_rsp_t r_rsp;
        data_t    word;
        int       idx;
        for (int n = 0; n < 5; n++) begin
            idx  = 1 + $urandom_range(`AXIL_NREGS - 2, 0);
            word = $urandom();
            do_write(reg_addr(idx), word, 4'hF, $urandom_range(10, 1), "stall_write", r_rsp);
            check_resp("stall_write", OKAY, r_rsp.resp);
            ref_bank[idx] = word;
            do_read(reg_addr(idx), $urandom_range(10, 1), "stall_read", r_rsp);
            check_data("stall_read", ref_bank[idx], r_rsp.data);
            check_resp("stall_read", OKAY, r_rsp.resp);
        end
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired after %0d ns, DUT stopped responding", TIMEOUT_NS);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        clk_i     = 1'b0;
        rst_ni    = 1'b0;
        cmd_valid = 1'b0;
        cmd_req   = '0;
        rsp_ready = 1'b1;
        errors    = 0;
        checks    = 0;
        void'($urandom(32'heb8ddf8e));
        foreach (ref_bank[i]) begin
            ref_bank[i] = '0;
        end
        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;
        if (!cmd_ready || rsp_valid) begin
            flag_failure("reset", "handshake outputs wrong after reset");
        end

        test_reset_values();
        test_full_writes();
        test_partial_strobes();
        test_error_responses();
        test_response_stall();

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
